/* common/opc_pkg.sv */
`default_nettype none

package opc_pkg;

   // Opcode field, bits 11..8 of the instruction
   typedef enum logic [3:0]
   {
      op_mov,
      op_and,
      op_or,
      op_xor,
      op_add,
      op_adc,
      op_sto,
      op_ld,
      op_ror,
      op_not,
      op_sub,
      op_sbc,
      op_cmp,
      op_cmpc,
      op_bswp,
      op_psr
   } opc_opcode_e;

   typedef enum logic [2:0]
   {
      st_fetch0,
      st_fetch1,
      st_ea_ed,
      st_rdmem,
      st_exec,
      st_wrmem,
      st_int
   } opc_state_e;

   // Condition tested before an instruction runs
   typedef enum logic [1:0]
   {
      pred_always,
      pred_carry,
      pred_zero,
      pred_sign
   } opc_pred_e;

   typedef struct packed
   {
      logic        pred_invert;
      opc_pred_e   pred_sel;
      logic        long_form;
      opc_opcode_e opcode;
      logic [3:0]  src;
      logic [3:0]  dst;
   } opc_instr_t;

   // Instruction word plus flags decoded once at load time
   typedef struct packed
   {
      logic       is_cmp;
      logic       get_psr;
      logic       put_psr;
      logic       rti;
      logic       is_sto;
      logic       is_ld;
      opc_instr_t instr;
   } opc_decode_t;

   typedef struct packed
   {
      logic swi;
      logic int_en;
      logic sign;
      logic carry;
      logic zero;
   } opc_flags_t;

   // Operand word of psr, either plain data or the status record
   typedef union packed
   {
      logic [15:0] data;
      struct packed
      {
         logic [10:0] pad;
         opc_flags_t  flags;
      } view;
   } opc_psr_u;

   localparam logic [15:0] INT_VECTOR = 16'h0002;

endpackage

`default_nettype wire

/* opc_cpu/opc_control.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_control
   import opc_pkg::*;
#(
   parameter int DATA_W = 16
)
(
   input  logic              clk,
   input  logic              reset_b,
   input  logic [DATA_W-1:0] din,
   input  opc_flags_t        flags,
   input  logic [DATA_W-1:0] rd_data,
   input  logic              int_b,
   output opc_state_e        state,
   output opc_decode_t       ir,
   output logic [DATA_W-1:0] operand,
   output logic [3:0]        rd_sel
);

   opc_instr_t din_instr;
   opc_state_e state_nxt;
   logic       pred_din;
   logic       pred_ir;
   logic       skip_ea_ed;
   logic       take_int;

   function automatic logic pred_ok(input opc_instr_t i, input opc_flags_t f);
      logic hit;
      case (i.pred_sel)
         pred_carry: hit = f.carry;
         pred_zero:  hit = f.zero;
         pred_sign:  hit = f.sign;
         default:    hit = 1'b1;
      endcase
      return hit ^ i.pred_invert;
   endfunction

   function automatic opc_decode_t decode(input opc_instr_t i);
      opc_decode_t d;
      d.instr   = i;
      d.is_cmp  = (i.opcode == op_cmp) || (i.opcode == op_cmpc);
      d.get_psr = (i.opcode == op_psr) && (i.dst != 4'hf) && (i.src == 4'h0);
      d.put_psr = (i.opcode == op_psr) && (i.src != 4'h0);
      d.rti     = (i.opcode == op_psr) && (i.dst == 4'hf) && (i.src == 4'h0);
      d.is_sto  = (i.opcode == op_sto);
      d.is_ld   = (i.opcode == op_ld);
      return d;
   endfunction

   assign din_instr  = din;
   assign pred_din   = pred_ok(din_instr, flags);
   assign pred_ir    = pred_ok(ir.instr, flags);
   assign skip_ea_ed = (ir.instr.src == 4'h0) && !ir.is_ld && !ir.is_sto;
   assign take_int   = flags.swi || (!int_b && flags.int_en);

   always_comb
   begin
      case (state)
         st_fetch0:
            state_nxt = din_instr.long_form ? st_fetch1 : (pred_din ? st_ea_ed : st_fetch0);
         st_fetch1:
            state_nxt = !pred_ir ? st_fetch0 : (skip_ea_ed ? st_exec : st_ea_ed);
         st_ea_ed:
            state_nxt = !pred_ir ? st_fetch0 :
                        ir.is_ld ? st_rdmem : (ir.is_sto ? st_wrmem : st_exec);
         st_rdmem:
            state_nxt = st_exec;
         // Next instruction word is already on din here
         st_exec:
            state_nxt = take_int ? st_int :
                        (ir.instr.dst == 4'hf) ? st_fetch0 :
                        din_instr.long_form ? st_fetch1 : st_ea_ed;
         st_wrmem:
            state_nxt = take_int ? st_int : st_fetch0;
         default:
            state_nxt = st_fetch0;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state <= st_fetch0;
      else
         state <= state_nxt;
   end

   always_ff @(posedge clk)
   begin
      case (state)
         st_fetch0, st_exec:
         begin
            rd_sel  <= din_instr.src;
            operand <= '0;
         end
         st_fetch1:
         begin
            rd_sel  <= skip_ea_ed ? ir.instr.dst : ir.instr.src;
            operand <= din;
         end
         // Effective address, source register plus immediate
         st_ea_ed:
         begin
            rd_sel  <= ir.instr.dst;
            operand <= rd_data + operand;
         end
         default:
         begin
            rd_sel  <= ir.instr.dst;
            operand <= din;
         end
      endcase
      if (state == st_fetch0 || state == st_exec)
         ir <= decode(din_instr);
   end

endmodule

`default_nettype wire

/* opc_cpu/opc_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_regfile
#(
   parameter int DATA_W = 16
)
(
   input  logic              clk,
   input  logic [3:0]        rd_sel,
   input  logic [DATA_W-1:0] pc,
   input  logic              we,
   input  logic [3:0]        wr_sel,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rd_data
);

   logic [DATA_W-1:0] regs [16];

   // Writes to r0 land in an entry that is never read
   always_ff @(posedge clk)
   begin
      if (we)
         regs[wr_sel] <= wr_data;
   end

   always_comb
   begin
      case (rd_sel)
         4'h0:
            rd_data = '0;
         // r15 is the live program counter
         4'hf:
            rd_data = pc;
         default:
            rd_data = regs[rd_sel];
      endcase
   end

endmodule

`default_nettype wire

/* opc_cpu/opc_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_alu
   import opc_pkg::*;
#(
   parameter int DATA_W = 16
)
(
   input  opc_decode_t       ir,
   input  logic [DATA_W-1:0] a,
   input  logic [DATA_W-1:0] b,
   input  opc_flags_t        flags,
   output logic [DATA_W-1:0] result,
   output opc_flags_t        next_flags
);

   logic [DATA_W:0] sum;
   logic            carry_out;
   opc_psr_u        psr_in;
   opc_psr_u        psr_out;

   always_comb
   begin
      psr_in.data        = b;
      psr_out.view.pad   = '0;
      psr_out.view.flags = flags;
   end

   // Subtract forms add the inverted operand
   always_comb
   begin
      case (ir.instr.opcode)
         op_add:
            sum = {1'b0, a} + {1'b0, b};
         op_adc:
            sum = {1'b0, a} + {1'b0, b} + flags.carry;
         op_sub, op_cmp:
            sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
         default:
            sum = {1'b0, a} + {1'b0, ~b} + flags.carry;
      endcase
   end

   always_comb
   begin
      result    = b;
      carry_out = flags.carry;
      case (ir.instr.opcode)
         op_and:
            result = a & b;
         op_or:
            result = a | b;
         op_xor:
            result = a ^ b;
         op_add, op_adc, op_sub, op_sbc, op_cmp, op_cmpc:
         begin
            result    = sum[DATA_W-1:0];
            carry_out = sum[DATA_W];
         end
         op_ror:
         begin
            result    = {flags.carry, b[DATA_W-1:1]};
            carry_out = b[0];
         end
         op_not:
            result = ~b;
         op_bswp:
            result = {b[DATA_W/2-1:0], b[DATA_W-1:DATA_W/2]};
         op_psr:
         begin
            if (ir.get_psr)
               result = psr_out.data;
         end
         default:
            result = b;
      endcase
   end

   always_comb
   begin
      next_flags = flags;
      if (ir.put_psr)
         next_flags = psr_in.view.flags;
      else if (ir.instr.dst != 4'hf)
      begin
         next_flags.sign  = result[DATA_W-1];
         next_flags.carry = carry_out;
         next_flags.zero  = (result == '0);
      end
   end

endmodule

`default_nettype wire

/* opc_cpu/opc_pc_psr.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_pc_psr
   import opc_pkg::*;
#(
   parameter int DATA_W = 16
)
(
   input  logic              clk,
   input  logic              reset_b,
   input  opc_state_e        state,
   input  opc_decode_t       ir,
   input  logic [DATA_W-1:0] result,
   input  opc_flags_t        next_flags,
   input  logic              int_b,
   output logic [DATA_W-1:0] pc,
   output opc_flags_t        flags
);

   logic [DATA_W-1:0] pc_sav;
   opc_flags_t        flags_sav;
   opc_flags_t        flags_exec;
   logic              in_service;
   logic              take_int;

   // Same condition the sequencer uses to leave exec for int
   assign take_int = flags.swi || (!int_b && flags.int_en);

   // No interrupt source can be armed while one is served
   always_comb
   begin
      flags_exec = next_flags;
      if (in_service)
      begin
         flags_exec.int_en = 1'b0;
         flags_exec.swi    = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         pc         <= '0;
         pc_sav     <= '0;
         flags      <= '0;
         flags_sav  <= '0;
         in_service <= 1'b0;
      end
      else
      begin
         case (state)
            st_fetch0, st_fetch1:
               pc <= pc + 1'b1;
            st_int:
            begin
               pc_sav       <= pc;
               flags_sav    <= {1'b0, flags.int_en, flags.sign, flags.carry, flags.zero};
               flags.int_en <= 1'b0;
               flags.swi    <= 1'b0;
               in_service   <= 1'b1;
               pc           <= INT_VECTOR;
            end
            st_exec:
            begin
               if (ir.rti)
               begin
                  pc         <= pc_sav;
                  flags      <= flags_sav;
                  in_service <= 1'b0;
               end
               else
               begin
                  flags <= flags_exec;
                  if (ir.instr.dst == 4'hf)
                     pc <= result;
                  else if (!take_int)
                     pc <= pc + 1'b1;
               end
            end
            default:
               pc <= pc;
         endcase
      end
   end

endmodule

`default_nettype wire

/* opc_cpu/opc_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_cpu
   import opc_pkg::*;
#(
   parameter int DATA_W = 16
)
(
   input  logic              clk,
   input  logic              reset_b,
   input  logic              int_b,
   input  logic [DATA_W-1:0] din,
   output logic [DATA_W-1:0] dout,
   output logic [DATA_W-1:0] address,
   output logic              rnw
);

   opc_state_e        state;
   opc_decode_t       ir;
   opc_flags_t        flags;
   opc_flags_t        next_flags;
   logic [DATA_W-1:0] operand;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] pc;
   logic [3:0]        rd_sel;
   logic [3:0]        wr_sel;
   logic              we;

   // Operand register addresses memory only in the data cycles
   assign address = (state == st_rdmem || state == st_wrmem) ? operand : pc;
   assign dout    = rd_data;
   assign rnw     = (state != st_wrmem);

   // Compares write r0, so only the flags change
   assign we     = (state == st_exec);
   assign wr_sel = ir.is_cmp ? 4'h0 : ir.instr.dst;

   opc_control #(.DATA_W(DATA_W)) u_control (
      .clk     (clk),
      .reset_b (reset_b),
      .din     (din),
      .flags   (flags),
      .rd_data (rd_data),
      .int_b   (int_b),
      .state   (state),
      .ir      (ir),
      .operand (operand),
      .rd_sel  (rd_sel)
   );

   opc_regfile #(.DATA_W(DATA_W)) u_regfile (
      .clk     (clk),
      .rd_sel  (rd_sel),
      .pc      (pc),
      .we      (we),
      .wr_sel  (wr_sel),
      .wr_data (result),
      .rd_data (rd_data)
   );

   opc_alu #(.DATA_W(DATA_W)) u_alu (
      .ir         (ir),
      .a          (rd_data),
      .b          (operand),
      .flags      (flags),
      .result     (result),
      .next_flags (next_flags)
   );

   opc_pc_psr #(.DATA_W(DATA_W)) u_pc_psr (
      .clk        (clk),
      .reset_b    (reset_b),
      .state      (state),
      .ir         (ir),
      .result     (result),
      .next_flags (next_flags),
      .int_b      (int_b),
      .pc         (pc),
      .flags      (flags)
   );

endmodule

`default_nettype wire

/* verification/opc_cpu_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module opc_cpu_sva
   import opc_pkg::*;
(
   input logic        clk,
   input logic        reset_b,
   input opc_state_e  state,
   input logic        rnw,
   input logic [15:0] address
);

   // A memory write lasts one cycle and follows the address add
   a_rnw_wrmem: assert property (@(posedge clk) disable iff (!reset_b)
      !rnw |-> ($past(state) == st_ea_ed) ##1 rnw)
      else $error("memory write is not a single cycle after ea_ed");

   a_state_legal: assert property (@(posedge clk) disable iff (!reset_b)
      state inside {st_fetch0, st_fetch1, st_ea_ed, st_rdmem, st_exec, st_wrmem, st_int})
      else $error("sequencer left its legal states");

   // First fetch out of reset
   a_reset_fetch: assert property (@(posedge clk) $rose(reset_b) |-> address == 16'h0000)
      else $error("first address after reset is not zero");

endmodule

bind opc_cpu opc_cpu_sva u_sva (
   .clk     (clk),
   .reset_b (reset_b),
   .state   (state),
   .rnw     (rnw),
   .address (address)
);

`default_nettype wire

/* verification/tb_opc_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_opc_cpu
   import opc_pkg::*;
();

   localparam int          CLK_PERIOD  = 40;
   localparam int          NUM_TESTS   = 26;
   localparam int          TEST_CYCLES = 48;
   localparam logic [15:0] MAIN_ADDR   = 16'h0010;
   localparam logic [15:0] RESULT_ADDR = 16'h0100;
   localparam logic [15:0] MARKER_ADDR = 16'h0101;
   localparam logic [15:0] MARKER      = 16'h1c3d;
   localparam logic [15:0] MEM_OFFSET  = 16'h0035;

   // One table row with operation, predicate, preset flags and the word it must store
   typedef struct packed
   {
      opc_opcode_e op;
      logic [2:0]  pred;
      opc_flags_t  flags;
      logic        irq;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] expected;
   } test_t;

   logic        clk;
   logic        reset_b;
   logic        int_b = 1'b1;
   logic [15:0] din;
   logic [15:0] dout;
   logic [15:0] address;
   logic        rnw;
   logic [15:0] mem [65536];
   logic        irq_armed = 1'b0;
   logic        store_seen = 1'b0;
   logic        marker_seen = 1'b0;
   logic [15:0] store_data;
   logic [15:0] marker_data;
   logic [15:0] prog_addr;
   test_t       tests [NUM_TESTS];
   int          num_tests;
   int          errors;
   int          failed;
   integer      seed;

   opc_cpu #(.DATA_W(16)) u_dut (
      .clk     (clk),
      .reset_b (reset_b),
      .int_b   (int_b),
      .din     (din),
      .dout    (dout),
      .address (address),
      .rnw     (rnw)
   );

   assign din = mem[address];

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (!reset_b)
      begin
         store_seen  <= 1'b0;
         marker_seen <= 1'b0;
      end
      else if (!rnw)
      begin
         mem[address] <= dout;
         if (address == RESULT_ADDR)
         begin
            store_seen <= 1'b1;
            store_data <= dout;
         end
         if (address == MARKER_ADDR)
         begin
            marker_seen <= 1'b1;
            marker_data <= dout;
         end
      end
      // Interrupt held low until the handler leaves its marker
      int_b <= !(irq_armed && !marker_seen);
   end

   initial
   begin
      #((NUM_TESTS * 60 + 200) * CLK_PERIOD);
      $display("Watchdog expired: the processor stopped writing results");
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [15:0] encode(input logic [2:0] pred, input logic long_form,
                                          input opc_opcode_e op, input logic [3:0] src,
                                          input logic [3:0] dst);
      return {pred, long_form, op, src, dst};
   endfunction

   function automatic logic [15:0] expected_word(input test_t t);
      logic hit;
      case (t.pred[1:0])
         2'd1:    hit = t.flags.carry;
         2'd2:    hit = t.flags.zero;
         2'd3:    hit = t.flags.sign;
         default: hit = 1'b1;
      endcase
      // Skipped instruction leaves r3 holding the first operand
      if ((hit ^ t.pred[2]) == 1'b0)
         return t.a;
      case (t.op)
         op_and:          return t.a & t.b;
         op_or:           return t.a | t.b;
         op_xor:          return t.a ^ t.b;
         op_add:          return t.a + t.b;
         op_adc:          return t.a + t.b + {15'b0, t.flags.carry};
         op_sub:          return t.a - t.b;
         op_sbc:          return t.a - t.b - {15'b0, !t.flags.carry};
         op_cmp, op_cmpc: return t.a;
         op_ror:          return {t.flags.carry, t.b[15:1]};
         op_not:          return ~t.b;
         op_bswp:         return {t.b[7:0], t.b[15:8]};
         op_psr:          return {11'b0, t.b[4:0]};
         default:         return t.b;
      endcase
   endfunction

   task automatic add_test(input opc_opcode_e op, input logic [2:0] pred,
                           input opc_flags_t flags, input logic irq);
      test_t       t;
      logic [31:0] rnd;
      t.op    = op;
      t.pred  = pred;
      t.flags = flags;
      t.irq   = irq;
      rnd     = $random(seed);
      t.a     = rnd[15:0];
      rnd     = $random(seed);
      t.b     = rnd[15:0];
      // Data base kept clear of program, handler and result words
      if (op == op_ld || op == op_sto)
         t.a = 16'h2000 | (t.a & 16'h0fff);
      // Software interrupt stays off while int_en is read back
      if (op == op_psr)
      begin
         t.b[4] = 1'b0;
         t.b[3] = 1'b1;
      end
      t.expected = expected_word(t);
      tests[num_tests] = t;
      num_tests++;
   endtask

   task automatic place(input logic [15:0] word);
      mem[prog_addr] = word;
      prog_addr = prog_addr + 16'h0001;
   endtask

   task automatic write_program(input test_t t);
      logic [15:0] self_addr;
      prog_addr = 16'h0000;
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'hf));
      place(MAIN_ADDR);
      // Handler at the interrupt vector stores a marker and returns
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'h5));
      place(MARKER);
      place(encode(3'b000, 1'b1, op_sto, 4'h0, 4'h5));
      place(MARKER_ADDR);
      place(encode(3'b000, 1'b0, op_psr, 4'h0, 4'hf));
      prog_addr = MAIN_ADDR;
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'h1));
      place(t.a);
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'h2));
      place(t.b);
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'h4));
      place({11'b0, t.flags});
      place(encode(3'b000, 1'b0, op_mov, 4'h1, 4'h3));
      place(encode(3'b000, 1'b0, op_psr, 4'h4, 4'h0));
      case (t.op)
         op_psr:
         begin
            place(encode(3'b000, 1'b0, op_psr, 4'h2, 4'h3));
            place(encode(3'b000, 1'b0, op_psr, 4'h0, 4'h3));
         end
         op_ld:
         begin
            mem[t.a + MEM_OFFSET] = t.b;
            place(encode(3'b000, 1'b1, op_ld, 4'h1, 4'h3));
            place(MEM_OFFSET);
         end
         op_sto:
         begin
            mem[t.a + MEM_OFFSET] = ~t.b;
            place(encode(3'b000, 1'b1, op_sto, 4'h1, 4'h2));
            place(MEM_OFFSET);
            place(encode(3'b000, 1'b1, op_ld, 4'h1, 4'h3));
            place(MEM_OFFSET);
         end
         default:
            place(encode(t.pred, 1'b0, t.op, 4'h2, 4'h3));
      endcase
      place(encode(3'b000, 1'b1, op_sto, 4'h0, 4'h3));
      place(RESULT_ADDR);
      self_addr = prog_addr;
      place(encode(3'b000, 1'b1, op_mov, 4'h0, 4'hf));
      place(self_addr);
   endtask

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic run_test(input test_t t, input int n);
      int cycles;
      int errors_before;
      errors_before = errors;
      @(posedge clk);
      reset_b   <= 1'b0;
      irq_armed <= t.irq;
      repeat (5) @(posedge clk);
      write_program(t);
      reset_b <= 1'b1;
      cycles = 0;
      while (!store_seen && cycles < TEST_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!store_seen)
      begin
         $display("Test %0d (%s): the processor never stored its result", n, t.op.name());
         errors++;
      end
      else
      begin
         check_value("stored result", store_data, t.expected);
         check_value("interrupt taken", {15'b0, marker_seen}, {15'b0, t.irq});
         if (t.irq)
            check_value("handler marker", marker_data, MARKER);
      end
      if (errors == errors_before)
         $display("Test %0d (%s): ok", n, t.op.name());
      else
      begin
         failed++;
         $display("Test %0d (%s): failed", n, t.op.name());
      end
   endtask

   initial
   begin
      reset_b   = 1'b0;
      seed      = 32'h065b_98ba;
      num_tests = 0;
      errors    = 0;
      failed    = 0;
      for (int i = 0; i < 65536; i++)
         mem[i] = i[15:0] ^ 16'hc35a;
      add_test(op_mov,  3'b000, 5'b00000, 1'b0);
      add_test(op_and,  3'b000, 5'b00000, 1'b0);
      add_test(op_or,   3'b000, 5'b00000, 1'b0);
      add_test(op_xor,  3'b000, 5'b00000, 1'b0);
      add_test(op_add,  3'b000, 5'b00000, 1'b0);
      add_test(op_add,  3'b000, 5'b00010, 1'b0);
      add_test(op_adc,  3'b000, 5'b00010, 1'b0);
      add_test(op_adc,  3'b000, 5'b00000, 1'b0);
      add_test(op_sub,  3'b000, 5'b00000, 1'b0);
      add_test(op_sbc,  3'b000, 5'b00010, 1'b0);
      add_test(op_sbc,  3'b000, 5'b00000, 1'b0);
      add_test(op_ror,  3'b000, 5'b00010, 1'b0);
      add_test(op_ror,  3'b000, 5'b00000, 1'b0);
      add_test(op_not,  3'b000, 5'b00000, 1'b0);
      add_test(op_bswp, 3'b000, 5'b00000, 1'b0);
      add_test(op_cmp,  3'b000, 5'b00000, 1'b0);
      add_test(op_cmpc, 3'b000, 5'b00010, 1'b0);
      add_test(op_psr,  3'b000, 5'b00000, 1'b0);
      add_test(op_ld,   3'b000, 5'b00000, 1'b0);
      add_test(op_sto,  3'b000, 5'b00000, 1'b0);
      // Predicated forms taken and skipped
      add_test(op_add,  3'b001, 5'b00000, 1'b0);
      add_test(op_sub,  3'b101, 5'b00000, 1'b0);
      add_test(op_xor,  3'b010, 5'b00001, 1'b0);
      add_test(op_or,   3'b011, 5'b00000, 1'b0);
      add_test(op_add,  3'b000, 5'b01000, 1'b1);
      add_test(op_adc,  3'b000, 5'b01010, 1'b1);
      for (int i = 0; i < num_tests; i++)
         run_test(tests[i], i);
      $display("%0d tests, %0d failed, %0d check errors", num_tests, failed, errors);
      if (failed == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
common/opc_pkg.sv
opc_cpu/opc_control.sv
opc_cpu/opc_regfile.sv
opc_cpu/opc_alu.sv
opc_cpu/opc_pc_psr.sv
opc_cpu/opc_cpu.sv
verification/opc_cpu_sva.sv
verification/tb_opc_cpu.sv
